// ==== common/core_cfg.svh ====
// Assumes RV32 with XLEN fixed at 32 and a word-aligned RESET_PC
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath and register file sizing
`define XLEN      32            // Data and address width
`define REG_COUNT 32            // Architectural registers including x0

// Fetch sequencing
`define RESET_PC  32'h0000_0000 // First fetch address out of reset
`define PC_STEP   32'd4         // Bytes per instruction word

`endif

// ==== common/rv_isa_pkg.sv ====
// Covers only OP, OP-IMM, LUI and AUIPC and treats every other opcode as a bubble
`default_nettype none

`include "core_cfg.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0]             word_t;    // One data or address word
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t; // x0 to x31

    // All-zero opcode field marks an empty slot
    localparam logic [6:0] OPCODE_BUBBLE = 7'b000_0000;

    typedef enum logic [6:0] {
        OP     = 7'b011_0011, // Register-register ALU
        OP_IMM = 7'b001_0011, // Register-immediate ALU
        LUI    = 7'b011_0111,
        AUIPC  = 7'b001_0111
    } opcode_e;

    // Same encoding as the older core's ALU select
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010, // Signed compare
        ALU_SLTU = 4'b0011, // Unsigned compare
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1001
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_REG  = 2'd0, // Forwarded rs1
        SRC_A_PC   = 2'd1, // AUIPC
        SRC_A_ZERO = 2'd2  // LUI
    } src_a_e;

endpackage

`default_nettype wire

// ==== common/pipe_pkg.sv ====
// Stage registers carry a valid bit only and have no stall or flush fields
`default_nettype none

package pipe_pkg;

    // Fetch to decode
    typedef struct packed {
        logic              valid;
        rv_isa_pkg::word_t pc;
        rv_isa_pkg::word_t instr;
    } if_id_t;

    // Decode to execute
    typedef struct packed {
        logic                 valid;
        rv_isa_pkg::word_t    pc;
        rv_isa_pkg::reg_idx_t rs1;      // Kept for forwarding compare
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::word_t    rs1_data; // Register file value after bypass
        rv_isa_pkg::word_t    rs2_data;
        rv_isa_pkg::word_t    imm;      // I-type or U-type, already extended
        rv_isa_pkg::alu_op_e  alu_op;
        rv_isa_pkg::src_a_e   src_a;
        logic                 use_imm;  // Operand B from imm instead of rs2
        rv_isa_pkg::reg_idx_t rd;
    } id_ex_t;

    // Execute to writeback, also the register file write port
    typedef struct packed {
        logic                 valid;
        rv_isa_pkg::word_t    pc;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    result;
    } ex_wb_t;

    // Retired instruction as seen from outside the core
    typedef struct packed {
        logic                 valid;
        rv_isa_pkg::word_t    pc;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    value;
    } retire_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
// PC advances one word every clock with no redirect and imem_data must be valid in the same cycle
`default_nettype none

`include "core_cfg.svh"

module fetch_stage (
    input  wire                    clk,
    input  wire                    rst,
    output rv_isa_pkg::word_t      imem_addr,
    input  wire rv_isa_pkg::word_t imem_data,
    output pipe_pkg::if_id_t       if_id
);

    rv_isa_pkg::word_t pc_q;
    pipe_pkg::if_id_t  if_id_d;
    pipe_pkg::if_id_t  if_id_q;
    logic              valid_q;

    always_comb begin
        if_id_d.valid = (imem_data[6:0] != rv_isa_pkg::OPCODE_BUBBLE); // Zero opcode is a bubble
        if_id_d.pc    = pc_q;
        if_id_d.instr = imem_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q    <= `RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= pc_q + `PC_STEP; // No branches so always sequential
            valid_q <= if_id_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        if_id_q <= if_id_d;
    end

    assign imem_addr = pc_q;

    always_comb begin
        if_id       = if_id_q;
        if_id.valid = valid_q; // Only the reset flop decides validity
    end

    // Fetch address must stay word aligned across the whole run
    a_pc_aligned : assert property (@(posedge clk) disable iff (rst)
        imem_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== decode/decode_stage.sv ====
// Unsupported opcodes and funct7 values outside the base set decode as bubbles or as the nearest op
`default_nettype none

module decode_stage (
    input  wire                    clk,
    input  wire                    rst,
    input  wire pipe_pkg::if_id_t  if_id,
    output rv_isa_pkg::reg_idx_t   rs1_idx,
    output rv_isa_pkg::reg_idx_t   rs2_idx,
    input  wire rv_isa_pkg::word_t rs1_data,
    input  wire rv_isa_pkg::word_t rs2_data,
    output pipe_pkg::id_ex_t       id_ex
);

    // funct3 to ALU op, bit 30 selects SUB only for OP and SRA for both
    function automatic rv_isa_pkg::alu_op_e alu_op_of(input logic [2:0] funct3,
                                                       input logic       alt,
                                                       input logic       is_reg);
        rv_isa_pkg::alu_op_e op;
        op = rv_isa_pkg::ALU_ADD;
        case (funct3)
            3'b000: op = (alt && is_reg) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            3'b001: op = rv_isa_pkg::ALU_SLL;
            3'b010: op = rv_isa_pkg::ALU_SLT;
            3'b011: op = rv_isa_pkg::ALU_SLTU;
            3'b100: op = rv_isa_pkg::ALU_XOR;
            3'b101: op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            3'b110: op = rv_isa_pkg::ALU_OR;
            3'b111: op = rv_isa_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic                funct7_b30;
    rv_isa_pkg::word_t   imm_i;
    rv_isa_pkg::word_t   imm_u;
    pipe_pkg::id_ex_t    id_ex_d;
    pipe_pkg::id_ex_t    id_ex_q;
    logic                valid_q;

    assign opcode     = rv_isa_pkg::opcode_e'(if_id.instr[6:0]);
    assign funct3     = if_id.instr[14:12];
    assign funct7_b30 = if_id.instr[30];
    assign rs1_idx    = if_id.instr[19:15]; // Straight to the register file
    assign rs2_idx    = if_id.instr[24:20];
    assign imm_i      = {{20{if_id.instr[31]}}, if_id.instr[31:20]}; // Sign extended
    assign imm_u      = {if_id.instr[31:12], 12'b0};

    always_comb begin
        id_ex_d.valid    = if_id.valid;
        id_ex_d.pc       = if_id.pc;
        id_ex_d.rs1      = rs1_idx;
        id_ex_d.rs2      = rs2_idx;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = imm_i;
        id_ex_d.alu_op   = rv_isa_pkg::ALU_ADD;
        id_ex_d.src_a    = rv_isa_pkg::SRC_A_REG;
        id_ex_d.use_imm  = 1'b0;
        id_ex_d.rd       = if_id.instr[11:7];
        case (opcode)
            rv_isa_pkg::OP: begin
                id_ex_d.alu_op = alu_op_of(funct3, funct7_b30, 1'b1);
            end
            rv_isa_pkg::OP_IMM: begin
                id_ex_d.alu_op  = alu_op_of(funct3, funct7_b30, 1'b0);
                id_ex_d.use_imm = 1'b1; // Shift amount sits in imm[4:0]
            end
            rv_isa_pkg::LUI: begin
                id_ex_d.imm     = imm_u;
                id_ex_d.src_a   = rv_isa_pkg::SRC_A_ZERO; // 0 + imm
                id_ex_d.use_imm = 1'b1;
            end
            rv_isa_pkg::AUIPC: begin
                id_ex_d.imm     = imm_u;
                id_ex_d.src_a   = rv_isa_pkg::SRC_A_PC; // pc + imm
                id_ex_d.use_imm = 1'b1;
            end
            default: id_ex_d.valid = 1'b0; // Not a kept group
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= id_ex_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_q <= id_ex_d;
    end

    always_comb begin
        id_ex       = id_ex_q;
        id_ex.valid = valid_q;
    end

endmodule

`default_nettype wire

// ==== decode/reg_file.sv ====
// Two combinational read ports with write-through and one write port fed by writeback
`default_nettype none

`include "core_cfg.svh"

module reg_file (
    input  wire                       clk,
    input  wire                       rst,
    input  wire rv_isa_pkg::reg_idx_t rs1_idx,
    input  wire rv_isa_pkg::reg_idx_t rs2_idx,
    output rv_isa_pkg::word_t         rs1_data,
    output rv_isa_pkg::word_t         rs2_data,
    input  wire pipe_pkg::ex_wb_t     wb
);

    rv_isa_pkg::word_t regs [`REG_COUNT];
    logic              wr_en;

    assign wr_en = wb.valid && (wb.rd != '0); // x0 is never written

    // x0 first, then the write landing this cycle, then the array
    function automatic rv_isa_pkg::word_t read_port(input rv_isa_pkg::reg_idx_t idx);
        rv_isa_pkg::word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wr_en && (wb.rd == idx)) begin
            val = wb.result;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_idx);
        rs2_data = read_port(rs2_idx);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // A retire aimed at x0 must leave it zero
    a_x0_zero : assert property (@(posedge clk) disable iff (rst)
        (wb.valid && wb.rd == '0) |=> (regs[0] == '0));

endmodule

`default_nettype wire

// ==== execute/alu.sv ====
// Purely combinational and uses only the low 5 bits of b as the shift amount
`default_nettype none

module alu (
    input  wire rv_isa_pkg::word_t   a,
    input  wire rv_isa_pkg::word_t   b,
    input  wire rv_isa_pkg::alu_op_e op,
    output rv_isa_pkg::word_t        result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_isa_pkg::ALU_ADD: begin
                result = a + b;
            end
            rv_isa_pkg::ALU_SUB: begin
                result = a - b;
            end
            rv_isa_pkg::ALU_SLL: begin
                result = a << shamt;
            end
            rv_isa_pkg::ALU_SLT: begin
                result = rv_isa_pkg::word_t'($signed(a) < $signed(b)); // Signed
            end
            rv_isa_pkg::ALU_SLTU: begin
                result = rv_isa_pkg::word_t'(a < b);
            end
            rv_isa_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            rv_isa_pkg::ALU_SRL: begin
                result = a >> shamt;
            end
            rv_isa_pkg::ALU_SRA: begin
                result = rv_isa_pkg::word_t'($signed(a) >>> shamt); // Keeps sign bit
            end
            rv_isa_pkg::ALU_OR: begin
                result = a | b;
            end
            rv_isa_pkg::ALU_AND: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== execute/execute_stage.sv ====
// Forwards from writeback only so it relies on the register file bypass for distance two
`default_nettype none

module execute_stage (
    input  wire                   clk,
    input  wire                   rst,
    input  wire pipe_pkg::id_ex_t id_ex,
    output pipe_pkg::ex_wb_t      ex_wb
);

    rv_isa_pkg::word_t rs1_val;
    rv_isa_pkg::word_t rs2_val;
    rv_isa_pkg::word_t op_a;
    rv_isa_pkg::word_t op_b;
    rv_isa_pkg::word_t alu_result;
    logic              fwd_rs1;
    logic              fwd_rs2;
    pipe_pkg::ex_wb_t  ex_wb_d;
    pipe_pkg::ex_wb_t  ex_wb_q;
    logic              valid_q;

    // Previous instruction sits in ex_wb and may not be in the file yet
    assign fwd_rs1 = ex_wb.valid && (ex_wb.rd != '0) && (ex_wb.rd == id_ex.rs1);
    assign fwd_rs2 = ex_wb.valid && (ex_wb.rd != '0) && (ex_wb.rd == id_ex.rs2);
    assign rs1_val = fwd_rs1 ? ex_wb.result : id_ex.rs1_data;
    assign rs2_val = fwd_rs2 ? ex_wb.result : id_ex.rs2_data;

    always_comb begin
        case (id_ex.src_a)
            rv_isa_pkg::SRC_A_PC:   op_a = id_ex.pc;
            rv_isa_pkg::SRC_A_ZERO: op_a = '0;
            default:                op_a = rv_isa_pkg::word_t'(rs1_val);
        endcase
    end

    assign op_b = id_ex.use_imm ? id_ex.imm : rs2_val;

    alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (id_ex.alu_op),
        .result (alu_result)
    );

    assign ex_wb_d = '{valid: id_ex.valid, pc: id_ex.pc, rd: id_ex.rd, result: alu_result};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= ex_wb_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_wb_q <= ex_wb_d;
    end

    always_comb begin
        ex_wb       = ex_wb_q;
        ex_wb.valid = valid_q; // Retire and write enable
    end

    // Decode must hand over a defined operation with every valid slot
    a_alu_op_known : assert property (@(posedge clk) disable iff (rst)
        id_ex.valid |-> !$isunknown(id_ex.alu_op));

endmodule

`default_nettype wire

// ==== verilog/rv_core.sv ====
// Instruction memory sits outside and must answer imem_addr combinationally in the same cycle
`default_nettype none

module rv_core (
    input  wire                    clk,
    input  wire                    rst,
    output rv_isa_pkg::word_t      imem_addr,
    input  wire rv_isa_pkg::word_t imem_data,
    output pipe_pkg::retire_t      retire
);

    pipe_pkg::if_id_t     if_id;
    pipe_pkg::id_ex_t     id_ex;
    pipe_pkg::ex_wb_t     ex_wb;
    rv_isa_pkg::reg_idx_t rs1_idx;
    rv_isa_pkg::reg_idx_t rs2_idx;
    rv_isa_pkg::word_t    rs1_data;
    rv_isa_pkg::word_t    rs2_data;

    fetch_stage u_fetch (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .if_id     (if_id)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst      (rst),
        .if_id    (if_id),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .id_ex    (id_ex)
    );

    // Written from writeback, read from decode
    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (ex_wb)
    );

    execute_stage u_execute (
        .clk   (clk),
        .rst   (rst),
        .id_ex (id_ex),
        .ex_wb (ex_wb)
    );

    assign retire = '{valid: ex_wb.valid, pc: ex_wb.pc, rd: ex_wb.rd, value: ex_wb.result};

endmodule

`default_nettype wire

// ==== tb/clk_gen.sv ====
// Clock of period 100 with reset held for the first 5 rising edges and released on a falling edge
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0; // Same edge as the other DUT inputs
    end

endmodule

`default_nettype wire

// ==== tb/tb_rv_core.sv ====
// Random program of kept opcodes and zero words, checked every cycle against an in-order model
`default_nettype none

`include "core_cfg.svh"

module tb_rv_core;

    localparam int PROG_LEN       = 200;
    localparam int TAIL_ZEROS     = 4;              // Program ends with bubbles
    localparam int LATENCY        = 3;              // imem_addr to retire
    localparam int RUN_EDGES      = PROG_LEN + LATENCY + 2;
    localparam int TIMEOUT_CYCLES = PROG_LEN + 60;  // Reset, drain and margin

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
    } exp_rec_t;

    logic              clk;
    logic              rst;
    rv_isa_pkg::word_t imem_addr;
    rv_isa_pkg::word_t imem_data;
    pipe_pkg::retire_t retire;

    logic [31:0] prog [PROG_LEN];
    logic        retires [PROG_LEN];   // Word is expected to retire
    exp_rec_t    exp_q [$];
    int          post_edges;           // Rising edges since reset release
    int          cycles = 0;
    bit          done;

    clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    rv_core u_dut (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // Mostly x0 to x7 so neighbours depend on each other
    function automatic logic [4:0] pick_reg();
        logic [4:0] r;
        if ($urandom_range(0, 7) != 0) begin
            r = 5'($urandom_range(0, 7));
        end else begin
            r = 5'($urandom_range(0, 31));
        end
        return r;
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          kind;
        kind = $urandom_range(0, 99);
        f3   = 3'($urandom_range(0, 7));
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        f7   = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
        if (kind < 10) begin
            w = '0;
        end else if (kind < 45) begin
            if (f3 != 3'd0 && f3 != 3'd5) begin
                f7 = 7'h00; // Only SUB and SRA use bit 30
            end
            w = {f7, rs2, rs1, f3, rd, 7'h33};
        end else if (kind < 80) begin
            if (f3 == 3'd1) begin
                imm = {7'h00, 5'($urandom)};
            end else if (f3 == 3'd5) begin
                imm = {f7, 5'($urandom)}; // SRLI or SRAI
            end else begin
                imm = 12'($urandom);
            end
            w = {imm, rs1, f3, rd, 7'h13};
        end else if (kind < 90) begin
            w = {20'($urandom), rd, 7'h37};
        end else begin
            w = {20'($urandom), rd, 7'h17};
        end
        return w;
    endfunction

    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic build_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            if (i >= PROG_LEN - TAIL_ZEROS) begin
                prog[i] = '0;
            end else begin
                prog[i] = random_instr();
            end
        end
    endtask

    // Sequential ISA model, one instruction at a time
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] w;
        logic [31:0] pc;
        logic [31:0] val;
        logic [4:0]  rd;
        logic [2:0]  f3;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            w          = prog[i];
            pc         = `RESET_PC + 32'(i) * `PC_STEP;
            rd         = w[11:7];
            f3         = w[14:12];
            retires[i] = 1'b1;
            case (w[6:0])
                7'h33: val = model_alu(f3, w[30], regs[w[19:15]], regs[w[24:20]]);
                7'h13: val = model_alu(f3, (f3 == 3'd5) && w[30], regs[w[19:15]],
                                       {{20{w[31]}}, w[31:20]});
                7'h37: val = {w[31:12], 12'h000};
                7'h17: val = pc + {w[31:12], 12'h000};
                default: begin
                    val        = '0;
                    retires[i] = 1'b0; // Zero word
                end
            endcase
            if (retires[i]) begin
                exp_q.push_back('{pc: pc, rd: rd, value: val});
                if (rd != 5'd0) begin
                    regs[rd] = val;
                end
            end
        end
    endtask

    function automatic logic [31:0] imem_lookup(input logic [31:0] addr);
        logic [31:0] idx;
        logic [31:0] word;
        idx  = (addr - `RESET_PC) / `PC_STEP;
        word = '0;
        if (idx < PROG_LEN) begin
            word = prog[idx];
        end
        return word;
    endfunction

    task automatic check_cycle();
        int       idx;
        logic     exp_valid;
        exp_rec_t expected_rec;
        idx       = post_edges - LATENCY; // Program word due on retire now
        exp_valid = 1'b0;
        if (idx >= 0 && idx < PROG_LEN) begin
            exp_valid = retires[idx];
        end
        check_value("fetch_address", `RESET_PC + 32'(post_edges) * `PC_STEP, imem_addr);
        check_value("retire_valid", 32'(exp_valid), 32'(retire.valid));
        if (retire.valid) begin
            expected_rec = exp_q.pop_front();
            check_value("retire_pc", expected_rec.pc, retire.pc);
            check_value("retire_rd", 32'(expected_rec.rd), 32'(retire.rd));
            check_value("retire_value", expected_rec.value, retire.value);
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            post_edges <= 0;
        end else begin
            post_edges <= post_edges + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    initial begin
        imem_data = '0;
        done      = 1'b0;
        void'($urandom(32'h2d3c_2ca3));
        build_program();
        run_model();
        while (!done) begin
            @(negedge clk);
            check_cycle();
            imem_data = imem_lookup(imem_addr);
            done      = (post_edges >= RUN_EDGES);
        end
        check_value("pending_retires", 32'd0, 32'(exp_q.size()));
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/rv_isa_pkg.sv
common/pipe_pkg.sv
verilog/fetch_stage.sv
decode/decode_stage.sv
decode/reg_file.sv
execute/alu.sv
execute/execute_stage.sv
verilog/rv_core.sv
tb/clk_gen.sv
tb/tb_rv_core.sv
